/* hw/esaxi_pkg.sv */
`default_nettype none

package esaxi_pkg;

   //####################
   // vector types
   //####################
   typedef logic [31:0]  aw_t;    // mesh / axi address
   typedef logic [31:0]  dw_t;    // data word
   typedef logic [11:0]  id_t;    // axi transaction id
   typedef logic [103:0] pkt_t;   // one mesh packet
   typedef logic [7:0]   len_t;   // axi burst length
   typedef logic [1:0]   size_t;  // axi size / packet datamode
   typedef logic [1:0]   burst_t; // axi burst type

   //####################
   // axi codes
   //####################
   localparam burst_t     BURST_INCR = 2'd1;   // fixed and wrap both step nothing
   localparam size_t      SIZE_WORD  = 2'd2;   // 0 byte, 1 half, 2 word
   localparam logic [1:0] RESP_OKAY  = 2'd0;

   //####################
   // packet layout
   //####################
   // bit 103 is spare and stays zero
   localparam int PKT_WRITE_BIT = 0;    // write flag
   localparam int PKT_MODE_LSB  = 1;    // datamode, 2 bits
   localparam int PKT_CTRL_LSB  = 3;    // ctrlmode, 4 bits, unused
   localparam int PKT_DST_LSB   = 7;    // destination address
   localparam int PKT_DATA_LSB  = 39;   // data word
   localparam int PKT_SRC_LSB   = 71;   // source address

   // this node on the mesh
   localparam logic [11:0] MESH_ID  = 12'h810;
   localparam logic [3:0]  GROUP_RR = 4'hd;   // read-response group

   // read responses come back here
   localparam aw_t RETURN_ADDR = {MESH_ID, GROUP_RR, 16'h0000};

endpackage

`default_nettype wire

/* hw/esaxi_write_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi_write_decode (
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   // aw channel
   input  esaxi_pkg::id_t      awid,
   input  esaxi_pkg::aw_t      awaddr,
   input  esaxi_pkg::size_t    awsize,
   input  esaxi_pkg::burst_t   awburst,
   input  logic                awvalid,
   output logic                awready,
   // w channel
   input  esaxi_pkg::dw_t      wdata,
   input  logic [3:0]          wstrb,
   input  logic                wlast,
   input  logic                wvalid,
   output logic                wready,
   // b channel
   output esaxi_pkg::id_t      bid,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   // mesh back-pressure
   input  logic                txwr_wait,
   // aligned beats toward packet_tx
   output logic                wr_beat,
   output esaxi_pkg::aw_t      wr_addr,
   output esaxi_pkg::size_t    wr_mode,
   output esaxi_pkg::dw_t      wr_data
);

   logic                aw_hs;          // address accepted
   logic                w_hs;           // data beat accepted
   logic                last_wr_beat;
   logic                write_active;   // between aw capture and last beat
   logic                b_pend;         // response waiting for bready
   esaxi_pkg::aw_t      aw_addr;        // running beat address
   esaxi_pkg::size_t    aw_size;
   esaxi_pkg::burst_t   aw_burst;

   assign aw_hs        = awready & awvalid;
   assign w_hs         = wready & wvalid;
   assign last_wr_beat = w_hs & wlast;

   assign bvalid = b_pend;
   assign bresp  = esaxi_pkg::RESP_OKAY;   // mesh writes never fail

   //####################
   // control
   //####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         awready      <= 1'b1;
         wready       <= 1'b0;
         write_active <= 1'b0;
         b_pend       <= 1'b0;
         wr_beat      <= 1'b0;
      end
      else
      begin
         if (aw_hs)
            awready <= 1'b0;                     // one write at a time
         else if (!write_active && !b_pend)
            awready <= 1'b1;                     // idle again once b taken
         if (aw_hs)
            write_active <= 1'b1;
         else if (last_wr_beat)
            write_active <= 1'b0;
         if (last_wr_beat)
            wready <= 1'b0;
         else if (write_active)
            wready <= ~txwr_wait;                // stall w channel on mesh wait
         if (last_wr_beat)
            b_pend <= 1'b1;
         else if (b_pend && bready)
            b_pend <= 1'b0;
         wr_beat <= w_hs;
      end
   end

   //####################
   // address and beat data
   //####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         bid      <= awid;                       // echoed on b
         aw_addr  <= awaddr;
         aw_size  <= awsize;
         aw_burst <= awburst;
      end
      else if (w_hs && aw_burst == esaxi_pkg::BURST_INCR)
      begin
         aw_addr[31:2] <= aw_addr[31:2] + 30'd1; // next word
         aw_addr[1:0]  <= 2'd0;
      end
      // narrow beats slide down to lane 0, lane index goes to addr lsbs
      wr_mode <= aw_size;
      if (wstrb[0] || aw_size == esaxi_pkg::SIZE_WORD)
      begin
         wr_data <= wdata;
         wr_addr <= {aw_addr[31:2], 2'd0};
      end
      else if (wstrb[1])
      begin
         wr_data <= {8'd0, wdata[31:8]};
         wr_addr <= {aw_addr[31:2], 2'd1};
      end
      else if (wstrb[2])
      begin
         wr_data <= {16'd0, wdata[31:16]};
         wr_addr <= {aw_addr[31:2], 2'd2};
      end
      else
      begin
         wr_data <= {24'd0, wdata[31:24]};       // top lane only
         wr_addr <= {aw_addr[31:2], 2'd3};
      end
   end

endmodule

`default_nettype wire

/* hw/esaxi_read_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi_read_decode (
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   // ar channel
   input  esaxi_pkg::id_t      arid,
   input  esaxi_pkg::aw_t      araddr,
   input  esaxi_pkg::len_t     arlen,
   input  esaxi_pkg::size_t    arsize,
   input  esaxi_pkg::burst_t   arburst,
   input  logic                arvalid,
   output logic                arready,
   // r channel handshake, watched at the top
   input  logic                rvalid,
   input  logic                rready,
   output esaxi_pkg::id_t      rid,
   output logic                rlast,
   // read requests toward packet_tx
   output logic                rd_req,
   output esaxi_pkg::aw_t      rd_addr,
   output esaxi_pkg::size_t    rd_mode
);

   logic                ar_hs;
   logic                r_hs;
   logic                read_active;    // ar capture through last r beat
   logic                ractive_q;      // for leading edge of read_active
   esaxi_pkg::len_t     ar_len;         // beats left after the current one
   esaxi_pkg::burst_t   ar_burst;

   assign ar_hs = arready & arvalid;
   assign r_hs  = rvalid & rready;

   //####################
   // control
   //####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready     <= 1'b0;
         read_active <= 1'b0;
         ractive_q   <= 1'b0;
         rd_req      <= 1'b0;
         rlast       <= 1'b0;
      end
      else
      begin
         if (ar_hs)
            arready <= 1'b0;
         else if (!read_active)
            arready <= 1'b1;                 // reopen a cycle after last beat
         if (ar_hs)
            read_active <= 1'b1;
         else if (r_hs && rlast)
            read_active <= 1'b0;
         ractive_q <= read_active;
         // first request on start of read, then one per returned beat
         rd_req <= (read_active & ~ractive_q) | (r_hs & ~rlast);
         if (ar_hs)
            rlast <= (arlen == 8'd0);        // single beat read
         else if (r_hs && ar_len == 8'd1)
            rlast <= 1'b1;
      end
   end

   //####################
   // captured ar fields
   //####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_hs)
      begin
         rid      <= arid;
         rd_addr  <= araddr;
         rd_mode  <= arsize;                 // also selects rdata replication
         ar_len   <= arlen;
         ar_burst <= arburst;
      end
      else if (r_hs)
      begin
         ar_len <= ar_len - 8'd1;
         if (ar_burst == esaxi_pkg::BURST_INCR)
         begin
            rd_addr[31:2] <= rd_addr[31:2] + 30'd1;
            rd_addr[1:0]  <= 2'd0;           // word aligned from here on
         end
      end
   end

endmodule

`default_nettype wire

/* hw/esaxi_packet_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi_packet_tx (
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   // write beats
   input  logic                wr_beat,
   input  esaxi_pkg::aw_t      wr_addr,
   input  esaxi_pkg::dw_t      wr_data,
   input  esaxi_pkg::size_t    wr_mode,
   // read requests
   input  logic                rd_req,
   input  esaxi_pkg::aw_t      rd_addr,
   input  esaxi_pkg::size_t    rd_mode,
   // mesh side
   output logic                txwr_access,
   output esaxi_pkg::pkt_t     txwr_packet,
   output logic                txrd_access,
   output esaxi_pkg::pkt_t     txrd_packet
);

   logic                wr_beat_q;      // extra write stage
   esaxi_pkg::aw_t      wr_addr_q;
   esaxi_pkg::dw_t      wr_data_q;
   esaxi_pkg::size_t    wr_mode_q;

   // field placement shared by both packet kinds
   function automatic esaxi_pkg::pkt_t pack(
      input logic              write,
      input esaxi_pkg::size_t  mode,
      input esaxi_pkg::aw_t    dst,
      input esaxi_pkg::dw_t    data,
      input esaxi_pkg::aw_t    src
   );
      esaxi_pkg::pkt_t p;
      p = '0;                                            // spare top bit stays 0
      p[esaxi_pkg::PKT_WRITE_BIT]      = write;
      p[esaxi_pkg::PKT_MODE_LSB +: 2]  = mode;
      p[esaxi_pkg::PKT_CTRL_LSB +: 4]  = 4'd0;           // no ctrlmode
      p[esaxi_pkg::PKT_DST_LSB +: 32]  = dst;
      p[esaxi_pkg::PKT_DATA_LSB +: 32] = data;
      p[esaxi_pkg::PKT_SRC_LSB +: 32]  = src;
      return p;
   endfunction

   //####################
   // access strobes
   //####################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         wr_beat_q   <= 1'b0;
         txwr_access <= 1'b0;
         txrd_access <= 1'b0;
      end
      else
      begin
         wr_beat_q   <= wr_beat;
         txwr_access <= wr_beat_q;
         txrd_access <= rd_req;               // one stage, same as its packet
      end
   end

   // payload, no reset
   always_ff @(posedge s_axi_aclk)
   begin
      wr_addr_q   <= wr_addr;
      wr_data_q   <= wr_data;
      wr_mode_q   <= wr_mode;
      txwr_packet <= pack(1'b1, wr_mode_q, wr_addr_q, wr_data_q, '0);
      txrd_packet <= pack(1'b0, rd_mode, rd_addr, '0, esaxi_pkg::RETURN_ADDR);
   end

endmodule

`default_nettype wire

/* hw/esaxi_read_result.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi_read_result (
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   // response packets from the mesh
   input  logic                rxrr_access,
   input  esaxi_pkg::pkt_t     rxrr_packet,
   input  esaxi_pkg::size_t    rd_mode,    // size of the read in flight
   // r channel
   input  logic                rready,
   output logic                rvalid,
   output esaxi_pkg::dw_t      rdata,
   output logic [1:0]          rresp
);

   esaxi_pkg::dw_t rx_data;

   assign rx_data = rxrr_packet[esaxi_pkg::PKT_DATA_LSB +: 32];
   assign rresp   = esaxi_pkg::RESP_OKAY;

   //####################
   // r beat register
   //####################
   // one read outstanding, so a held beat is never overwritten
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rvalid <= 1'b0;
      else if (rxrr_access)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (rxrr_access)
         case (rd_mode)
            2'd0:    rdata <= {4{rx_data[7:0]}};    // byte on every lane
            2'd1:    rdata <= {2{rx_data[15:0]}};   // half on both halves
            default: rdata <= rx_data;
         endcase
   end

endmodule

`default_nettype wire

/* hw/esaxi.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi (
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   // aw channel
   input  esaxi_pkg::id_t      s_axi_awid,
   input  esaxi_pkg::aw_t      s_axi_awaddr,
   input  esaxi_pkg::size_t    s_axi_awsize,
   input  esaxi_pkg::burst_t   s_axi_awburst,
   input  logic                s_axi_awvalid,
   output logic                s_axi_awready,
   // w channel
   input  esaxi_pkg::dw_t      s_axi_wdata,
   input  logic [3:0]          s_axi_wstrb,
   input  logic                s_axi_wlast,
   input  logic                s_axi_wvalid,
   output logic                s_axi_wready,
   // b channel
   output esaxi_pkg::id_t      s_axi_bid,
   output logic [1:0]          s_axi_bresp,
   output logic                s_axi_bvalid,
   input  logic                s_axi_bready,
   // ar channel
   input  esaxi_pkg::id_t      s_axi_arid,
   input  esaxi_pkg::aw_t      s_axi_araddr,
   input  esaxi_pkg::len_t     s_axi_arlen,
   input  esaxi_pkg::size_t    s_axi_arsize,
   input  esaxi_pkg::burst_t   s_axi_arburst,
   input  logic                s_axi_arvalid,
   output logic                s_axi_arready,
   // r channel
   output esaxi_pkg::id_t      s_axi_rid,
   output esaxi_pkg::dw_t      s_axi_rdata,
   output logic                s_axi_rlast,
   output logic [1:0]          s_axi_rresp,
   output logic                s_axi_rvalid,
   input  logic                s_axi_rready,
   // mesh
   output logic                txwr_access,
   output esaxi_pkg::pkt_t     txwr_packet,
   input  logic                txwr_wait,
   output logic                txrd_access,
   output esaxi_pkg::pkt_t     txrd_packet,
   input  logic                rxrr_access,
   input  esaxi_pkg::pkt_t     rxrr_packet
);

   logic                wr_beat;        // aligned write beat
   esaxi_pkg::aw_t      wr_addr;
   esaxi_pkg::dw_t      wr_data;
   esaxi_pkg::size_t    wr_mode;
   logic                rd_req;         // read request pulse
   esaxi_pkg::aw_t      rd_addr;
   esaxi_pkg::size_t    rd_mode;        // to packet_tx and read_result

   esaxi_write_decode u_write_decode (
      .s_axi_aclk, .s_axi_aresetn,
      .awid    (s_axi_awid),    .awaddr (s_axi_awaddr), .awsize (s_axi_awsize),
      .awburst (s_axi_awburst), .awvalid(s_axi_awvalid), .awready(s_axi_awready),
      .wdata   (s_axi_wdata),   .wstrb  (s_axi_wstrb),  .wlast  (s_axi_wlast),
      .wvalid  (s_axi_wvalid),  .wready (s_axi_wready),
      .bid     (s_axi_bid),     .bresp  (s_axi_bresp),  .bvalid (s_axi_bvalid),
      .bready  (s_axi_bready),  .txwr_wait,
      .wr_beat, .wr_addr, .wr_mode, .wr_data
   );

   esaxi_read_decode u_read_decode (
      .s_axi_aclk, .s_axi_aresetn,
      .arid    (s_axi_arid),    .araddr (s_axi_araddr), .arlen  (s_axi_arlen),
      .arsize  (s_axi_arsize),  .arburst(s_axi_arburst),
      .arvalid (s_axi_arvalid), .arready(s_axi_arready),
      .rvalid  (s_axi_rvalid),  .rready (s_axi_rready),
      .rid     (s_axi_rid),     .rlast  (s_axi_rlast),
      .rd_req, .rd_addr, .rd_mode
   );

   esaxi_packet_tx u_packet_tx (
      .s_axi_aclk, .s_axi_aresetn,
      .wr_beat, .wr_addr, .wr_data, .wr_mode,
      .rd_req, .rd_addr, .rd_mode,
      .txwr_access, .txwr_packet, .txrd_access, .txrd_packet
   );

   esaxi_read_result u_read_result (
      .s_axi_aclk, .s_axi_aresetn,
      .rxrr_access, .rxrr_packet, .rd_mode,
      .rready  (s_axi_rready),  .rvalid (s_axi_rvalid),
      .rdata   (s_axi_rdata),   .rresp  (s_axi_rresp)
   );

endmodule

`default_nettype wire

/* testbench/esaxi_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi_chk (
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   input  logic                s_axi_bvalid,
   input  logic                s_axi_bready,
   input  logic                s_axi_arready,
   input  logic                s_axi_rvalid,
   input  logic                s_axi_rready,
   input  esaxi_pkg::dw_t      s_axi_rdata,
   input  logic                s_axi_rlast,
   input  logic                txwr_access,
   input  logic                txrd_access
);

   //####################
   // axi channel holds
   //####################
   bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
      else $error("bvalid dropped before bready");

   // r beat frozen while master stalls
   r_beat_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_rvalid && !s_axi_rready |=>
         s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rlast))
      else $error("r beat changed before rready");

   ar_closed: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_rvalid |-> !s_axi_arready)   // single read in flight
      else $error("arready high during an r beat");

   // strobes quiet on first cycle out of reset
   access_quiet: assert property (@(posedge s_axi_aclk)
      $rose(s_axi_aresetn) |=> !txwr_access && !txrd_access)
      else $error("mesh access strobe high right after reset");

endmodule

bind esaxi esaxi_chk u_esaxi_chk (
   .s_axi_aclk, .s_axi_aresetn, .s_axi_bvalid, .s_axi_bready, .s_axi_arready,
   .s_axi_rvalid, .s_axi_rready, .s_axi_rdata, .s_axi_rlast,
   .txwr_access, .txrd_access
);

`default_nettype wire

/* testbench/tb_esaxi.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_esaxi;

   localparam int WAIT_LIMIT = 200;   // cycles per wait loop

   logic                s_axi_aclk;
   logic                s_axi_aresetn;
   esaxi_pkg::id_t      s_axi_awid;
   esaxi_pkg::aw_t      s_axi_awaddr;
   esaxi_pkg::size_t    s_axi_awsize;
   esaxi_pkg::burst_t   s_axi_awburst;
   logic                s_axi_awvalid;
   logic                s_axi_awready;
   esaxi_pkg::dw_t      s_axi_wdata;
   logic [3:0]          s_axi_wstrb;
   logic                s_axi_wlast;
   logic                s_axi_wvalid;
   logic                s_axi_wready;
   esaxi_pkg::id_t      s_axi_bid;
   logic [1:0]          s_axi_bresp;
   logic                s_axi_bvalid;
   logic                s_axi_bready;
   esaxi_pkg::id_t      s_axi_arid;
   esaxi_pkg::aw_t      s_axi_araddr;
   esaxi_pkg::len_t     s_axi_arlen;
   esaxi_pkg::size_t    s_axi_arsize;
   esaxi_pkg::burst_t   s_axi_arburst;
   logic                s_axi_arvalid;
   logic                s_axi_arready;
   esaxi_pkg::id_t      s_axi_rid;
   esaxi_pkg::dw_t      s_axi_rdata;
   logic                s_axi_rlast;
   logic [1:0]          s_axi_rresp;
   logic                s_axi_rvalid;
   logic                s_axi_rready;
   logic                txwr_access;
   esaxi_pkg::pkt_t     txwr_packet;
   logic                txwr_wait;
   logic                txrd_access;
   esaxi_pkg::pkt_t     txrd_packet;
   logic                rxrr_access;
   esaxi_pkg::pkt_t     rxrr_packet;

   integer              seed = 32'h8290_68ee;
   int                  errors;
   int                  cur;          // entry under test or -1 for reset
   logic                timed_out;
   int                  b_count;      // write responses seen
   logic                bvalid_q;
   logic [31:0]         rsp;
   esaxi_pkg::pkt_t     wr_q [$];     // txwr packets as they leave
   esaxi_pkg::pkt_t     rd_q [$];     // txrd packets as they leave
   logic [31:0]         rx_q [$];     // data the responder sent back

   //####################
   // transaction table
   //####################
   logic                kinds  [16];  // 1 for read
   esaxi_pkg::id_t      ids    [16];
   esaxi_pkg::aw_t      addrs  [16];
   esaxi_pkg::size_t    sizes  [16];
   esaxi_pkg::burst_t   bursts [16];
   int                  nbeats [16];
   logic [3:0]          strbs  [16];
   logic [31:0]         dseeds [16];  // first write beat data plus beat number
   int                  n_entries;

   esaxi u_esaxi (.*);

   initial
   begin
      s_axi_aclk = 1'b0;
      forever #4 s_axi_aclk = ~s_axi_aclk;
   end

   task automatic add_entry(input logic k, input esaxi_pkg::id_t i, input esaxi_pkg::aw_t a,
                            input esaxi_pkg::size_t s, input esaxi_pkg::burst_t bu,
                            input int n, input logic [3:0] st, input logic [31:0] ds);
      kinds[n_entries]  = k;
      ids[n_entries]    = i;
      addrs[n_entries]  = a;
      sizes[n_entries]  = s;
      bursts[n_entries] = bu;
      nbeats[n_entries] = n;
      strbs[n_entries]  = st;
      dseeds[n_entries] = ds;
      n_entries++;
   endtask

   task automatic mismatch(input string what, input esaxi_pkg::pkt_t got,
                           input esaxi_pkg::pkt_t exp);
      $display("[ERROR] %0t: entry %0d %s is %0h, expected %0h", $time, cur, what, got, exp);
      errors++;
   endtask

   task automatic flag_timeout(input string what);
      $display("timeout: %s never came in entry %0d", what, cur);
      timed_out = 1'b1;
   endtask

   // beat address is word aligned after the first incr beat
   function automatic esaxi_pkg::aw_t beat_addr(input esaxi_pkg::aw_t start,
                                                input esaxi_pkg::burst_t burst, input int b);
      if (b == 0 || burst != esaxi_pkg::BURST_INCR)
         return start;
      return {start[31:2], 2'b00} + 32'(4 * b);
   endfunction

   //####################
   // mesh side
   //####################
   initial
   begin
      bvalid_q = 1'b0;
      forever
      begin
         @(negedge s_axi_aclk);
         if (txwr_access)
            wr_q.push_back(txwr_packet);
         if (s_axi_bvalid && !bvalid_q)
            b_count++;                        // counts responses rather than cycles
         bvalid_q = s_axi_bvalid;
      end
   end

   // responder answers each read request 3 cycles later
   initial
   begin
      forever
      begin
         @(negedge s_axi_aclk);
         if (txrd_access)
         begin
            rd_q.push_back(txrd_packet);
            rsp = $random(seed);
            rx_q.push_back(rsp);
            repeat (3) @(negedge s_axi_aclk);
            rxrr_packet = '0;
            rxrr_packet[esaxi_pkg::PKT_DATA_LSB +: 32] = rsp;
            rxrr_access = 1'b1;
            @(negedge s_axi_aclk);
            rxrr_access = 1'b0;
         end
      end
   end

   //####################
   // axi master
   //####################
   task automatic write_txn(input int e);
      int                 n;
      int                 b;
      int                 k;
      int                 lane;
      logic               hs;
      logic [31:0]        r;
      logic [31:0]        wd;
      esaxi_pkg::aw_t     a;
      esaxi_pkg::pkt_t    p;
      esaxi_pkg::pkt_t    exp_pkt;
      s_axi_awid    = ids[e];
      s_axi_awaddr  = addrs[e];
      s_axi_awsize  = sizes[e];
      s_axi_awburst = bursts[e];
      s_axi_awvalid = 1'b1;
      n = 0;
      while (!s_axi_awready && n < WAIT_LIMIT)
      begin
         @(negedge s_axi_aclk);
         n++;
      end
      if (!s_axi_awready)
      begin
         flag_timeout("awready");
         return;
      end
      @(negedge s_axi_aclk);                  // aw taken on the edge just passed
      s_axi_awvalid = 1'b0;
      b = 0;
      n = 0;
      b_count = 0;
      wr_q.delete();
      s_axi_wdata  = dseeds[e];
      s_axi_wstrb  = strbs[e];
      s_axi_wlast  = (nbeats[e] == 1);
      s_axi_wvalid = 1'b1;
      while (b < nbeats[e] && n < WAIT_LIMIT)
      begin
         hs = s_axi_wready;                   // beat moves on the coming edge
         if (nbeats[e] > 1)
         begin
            r = $random(seed);
            txwr_wait = r[0];                 // random mesh stall
         end
         @(negedge s_axi_aclk);
         n++;
         if (hs)
         begin
            b++;
            s_axi_wdata  = dseeds[e] + 32'(b);
            s_axi_wlast  = (b == nbeats[e] - 1);
            s_axi_wvalid = (b < nbeats[e]);
         end
      end
      txwr_wait = 1'b0;
      if (b < nbeats[e])
      begin
         flag_timeout("wready");
         return;
      end
      n = 0;
      while (!s_axi_bvalid && n < WAIT_LIMIT)
      begin
         @(negedge s_axi_aclk);
         n++;
      end
      if (!s_axi_bvalid)
      begin
         flag_timeout("bvalid");
         return;
      end
      if (s_axi_bid !== ids[e])
         mismatch("bid", 104'(s_axi_bid), 104'(ids[e]));
      if (s_axi_bresp !== esaxi_pkg::RESP_OKAY)
         mismatch("bresp", 104'(s_axi_bresp), 104'(esaxi_pkg::RESP_OKAY));
      @(negedge s_axi_aclk);                  // leave bvalid waiting a cycle
      s_axi_bready = 1'b1;
      @(negedge s_axi_aclk);
      s_axi_bready = 1'b0;
      n = 0;
      while (wr_q.size() < nbeats[e] && n < WAIT_LIMIT)
      begin
         @(negedge s_axi_aclk);
         n++;
      end
      repeat (4) @(negedge s_axi_aclk);       // room for a stray packet or response
      if (wr_q.size() != nbeats[e])
      begin
         $display("[ERROR] %0t: entry %0d gave %0d write packets, expected %0d",
                  $time, e, wr_q.size(), nbeats[e]);
         errors++;
      end
      if (b_count != 1)
      begin
         $display("[ERROR] %0t: entry %0d gave %0d write responses", $time, e, b_count);
         errors++;
      end
      // lowest strobe lane past 0 sets shift and addr lsbs
      lane = 0;
      if (!strbs[e][0] && sizes[e] != esaxi_pkg::SIZE_WORD)
         for (k = 3; k >= 1; k--)
            if (strbs[e][k])
               lane = k;
      for (b = 0; b < nbeats[e] && wr_q.size() > 0; b++)
      begin
         p  = wr_q.pop_front();
         a  = beat_addr(addrs[e], bursts[e], b);
         wd = (dseeds[e] + 32'(b)) >> (8 * lane);
         exp_pkt = {1'b0, 32'h0, wd, a[31:2], 2'(lane), 4'h0, sizes[e], 1'b1};
         if (p !== exp_pkt)
            mismatch($sformatf("txwr packet %0d", b), p, exp_pkt);
      end
   endtask

   task automatic read_txn(input int e);
      int                 n;
      int                 b;
      logic [31:0]        d;
      logic [31:0]        exp_data;
      esaxi_pkg::aw_t     a;
      esaxi_pkg::pkt_t    p;
      esaxi_pkg::pkt_t    exp_pkt;
      rd_q.delete();
      rx_q.delete();
      s_axi_arid    = ids[e];
      s_axi_araddr  = addrs[e];
      s_axi_arlen   = 8'(nbeats[e] - 1);
      s_axi_arsize  = sizes[e];
      s_axi_arburst = bursts[e];
      s_axi_arvalid = 1'b1;
      n = 0;
      while (!s_axi_arready && n < WAIT_LIMIT)
      begin
         @(negedge s_axi_aclk);
         n++;
      end
      if (!s_axi_arready)
      begin
         flag_timeout("arready");
         return;
      end
      @(negedge s_axi_aclk);
      s_axi_arvalid = 1'b0;
      for (b = 0; b < nbeats[e]; b++)
      begin
         n = 0;
         while (!s_axi_rvalid && n < WAIT_LIMIT)
         begin
            @(negedge s_axi_aclk);
            n++;
         end
         if (!s_axi_rvalid)
         begin
            flag_timeout("rvalid");
            return;
         end
         if (rd_q.size() == 0)
         begin
            $display("r beat %0d of entry %0d came with no read request on the mesh", b, e);
            errors++;
            return;
         end
         p = rd_q.pop_front();
         d = rx_q.pop_front();
         a = beat_addr(addrs[e], bursts[e], b);
         exp_pkt = {1'b0, esaxi_pkg::RETURN_ADDR, 32'h0, a, 4'h0, sizes[e], 1'b0};
         if (p !== exp_pkt)
            mismatch($sformatf("txrd packet %0d", b), p, exp_pkt);
         case (sizes[e])
            2'd0:    exp_data = {4{d[7:0]}};    // byte on all lanes
            2'd1:    exp_data = {2{d[15:0]}};
            default: exp_data = d;
         endcase
         if (s_axi_rdata !== exp_data)
            mismatch($sformatf("rdata %0d", b), 104'(s_axi_rdata), 104'(exp_data));
         if (s_axi_rlast !== (b == nbeats[e] - 1))
            mismatch($sformatf("rlast %0d", b), 104'(s_axi_rlast), 104'(b == nbeats[e] - 1));
         if (s_axi_rid !== ids[e])
            mismatch("rid", 104'(s_axi_rid), 104'(ids[e]));
         if (s_axi_rresp !== esaxi_pkg::RESP_OKAY)
            mismatch("rresp", 104'(s_axi_rresp), 104'(esaxi_pkg::RESP_OKAY));
         repeat (b) @(negedge s_axi_aclk);    // hold the beat a while
         s_axi_rready = 1'b1;
         @(negedge s_axi_aclk);
         s_axi_rready = 1'b0;
      end
      repeat (4) @(negedge s_axi_aclk);
      if (rd_q.size() != 0)
      begin
         $display("[ERROR] %0t: entry %0d sent %0d extra read requests", $time, e, rd_q.size());
         errors++;
      end
   endtask

   //####################
   // main sequence
   //####################
   initial
   begin
      int ran;
      int start_err;
      s_axi_aresetn = 1'b0;
      s_axi_awid    = '0;
      s_axi_awaddr  = '0;
      s_axi_awsize  = '0;
      s_axi_awburst = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wlast   = 1'b0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_arid    = '0;
      s_axi_araddr  = '0;
      s_axi_arlen   = '0;
      s_axi_arsize  = '0;
      s_axi_arburst = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      txwr_wait     = 1'b0;
      rxrr_access   = 1'b0;
      rxrr_packet   = '0;
      errors        = 0;
      timed_out     = 1'b0;
      b_count       = 0;
      n_entries     = 0;
      ran           = 0;
      // kind, id, addr, size, burst, beats, strobes, data
      add_entry(1'b0, 12'h011, 32'h0000_1000, 2'd2, 2'd1, 1, 4'hf, 32'h1234_5678);
      add_entry(1'b0, 12'h012, 32'h0000_2000, 2'd0, 2'd1, 1, 4'h1, 32'h0000_00a5);
      add_entry(1'b0, 12'h013, 32'h0000_2001, 2'd0, 2'd1, 1, 4'h2, 32'h0000_5a00);
      add_entry(1'b0, 12'h014, 32'h0000_2002, 2'd0, 2'd1, 1, 4'h4, 32'h0077_0000);
      add_entry(1'b0, 12'h015, 32'h0000_2003, 2'd0, 2'd1, 1, 4'h8, 32'h9900_0000);
      add_entry(1'b0, 12'h016, 32'h0000_2004, 2'd1, 2'd1, 1, 4'h3, 32'h0000_beef);
      add_entry(1'b0, 12'h017, 32'h0000_2006, 2'd1, 2'd1, 1, 4'hc, 32'hdead_0000);
      add_entry(1'b0, 12'h0a7, 32'h0000_3006, 2'd2, 2'd1, 4, 4'hf, 32'h3000_0000);
      add_entry(1'b1, 12'h3c1, 32'h0000_4000, 2'd2, 2'd1, 4, 4'h0, 32'h0);
      add_entry(1'b1, 12'h3c2, 32'h0000_5003, 2'd0, 2'd0, 2, 4'h0, 32'h0);
      add_entry(1'b1, 12'h3c3, 32'h0000_6002, 2'd1, 2'd0, 2, 4'h0, 32'h0);
      repeat (5) @(negedge s_axi_aclk);
      cur = -1;
      if (s_axi_awready !== 1'b1)
         mismatch("awready after reset", 104'(s_axi_awready), 104'(1'b1));
      if ({s_axi_wready, s_axi_arready, s_axi_bvalid, s_axi_rvalid,
           txwr_access, txrd_access} !== 6'b0)
         mismatch("controls after reset", 104'({s_axi_wready, s_axi_arready, s_axi_bvalid,
                  s_axi_rvalid, txwr_access, txrd_access}), 104'(6'b0));
      $display("reset: %s", (errors == 0) ? "ok" : "failed");
      s_axi_aresetn = 1'b1;
      for (int e = 0; e < n_entries && !timed_out; e++)
      begin
         cur = e;
         start_err = errors;
         if (kinds[e])
            read_txn(e);
         else
            write_txn(e);
         ran++;
         $display("entry %0d %s id %h addr %h beats %0d: %s", e, kinds[e] ? "read " : "write",
                  ids[e], addrs[e], nbeats[e],
                  (errors == start_err && !timed_out) ? "ok" : "failed");
      end
      $display("%0d of %0d entries run, %0d errors, %0s", ran, n_entries, errors,
               timed_out ? "stopped on a timeout" : "no timeouts");
      if (errors == 0 && !timed_out)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
hw/esaxi_pkg.sv
hw/esaxi_write_decode.sv
hw/esaxi_read_decode.sv
hw/esaxi_packet_tx.sv
hw/esaxi_read_result.sv
hw/esaxi.sv
testbench/esaxi_chk.sv
testbench/tb_esaxi.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_esaxi
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, fail unless the pass line appears"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
